/* list.f */
source/serial_alu_pkg.sv
source/alu_ctrl_if.sv
source/ser_add.sv
source/ser_lt.sv
source/ser_shift.sv
source/serial_alu.sv
source/alu_sequencer.sv
source/serial_alu_top.sv
verification/serial_alu_props.sv
verification/serial_alu_tb.sv

/* verification/serial_alu_tb.sv */
`timescale 1ns/100ps

module serial_alu_tb
   import serial_alu_pkg::*;
();

   localparam int CLK_NS     = 40;
   localparam int N_RAND     = 8;
   localparam int N_TESTS    = 82 + 11 * N_RAND;  // operations issued.
   localparam int OP_CYCLES  = 70;
   localparam int DONE_EDGES = 65;

   logic            clk;
   logic            i_reset;
   logic            i_start;
   alu_op_t         i_op;
   logic [XLEN-1:0] i_rs1;
   logic [XLEN-1:0] i_op_b;
   logic            o_busy;
   logic            o_done;
   logic            o_cmp;
   logic [XLEN-1:0] o_result;

   logic [31:0]     rng_state;
   int              edge_cnt     = 0;
   int              errors       = 0;
   int              tests_run    = 0;
   int              tests_failed = 0;
   string           name_q[$];
   logic [XLEN:0]   exp_q[$];     // {cmp, result}.
   bit              cmp_q[$];
   int              edge_q[$];

   serial_alu_top dut (.*);

   initial begin
      clk = 1'b0;
      forever #(CLK_NS / 2) clk = ~clk;
   end

   always @(posedge clk) edge_cnt <= edge_cnt + 1;

   initial begin : watchdog
      #((N_TESTS * OP_CYCLES + 4 + 200) * CLK_NS);
      $display("timeout: the DUT did not finish all operations in time");
      $display("Verification failed");
      $finish;
   end

   // ################################################
   // helpers
   function automatic logic [31:0] xorshift32();
      logic [31:0] x;
      x = rng_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng_state = x;
      return x;
   endfunction

   function automatic logic [XLEN-1:0] corner(input int i);
      case (i)
         0:       return '0;
         1:       return '1;
         2:       return 32'h8000_0000;
         default: return 32'h0000_0001;
      endcase
   endfunction

   function automatic logic [XLEN:0] ref_alu(input alu_op_t op, input logic [XLEN-1:0] a,
                                             input logic [XLEN-1:0] b);
      logic [XLEN-1:0] res;
      logic            lt_s;
      logic            lt_u;
      logic            cmp;
      lt_s = $signed(a) < $signed(b);
      lt_u = a < b;
      cmp  = (a == b);
      case (op)
         OP_ADD:  res = a + b;
         OP_SUB:  res = a - b;
         OP_AND:  res = a & b;
         OP_OR:   res = a | b;
         OP_XOR:  res = a ^ b;
         OP_XNOR: res = ~(a ^ b);
         OP_SLT: begin
            res = XLEN'(lt_s);
            cmp = lt_s;
         end
         OP_SLTU: begin
            res = XLEN'(lt_u);
            cmp = lt_u;
         end
         OP_SLL:  res = a << b[SHAMT_W-1:0];
         OP_SRL:  res = a >> b[SHAMT_W-1:0];
         OP_SRA:  res = $unsigned($signed(a) >>> b[SHAMT_W-1:0]);
         default: res = '0;
      endcase
      return {cmp, res};
   endfunction

   function automatic bit cmp_defined(input alu_op_t op);
      case (op)
         OP_AND, OP_OR, OP_XOR, OP_XNOR, OP_SLT, OP_SLTU: return 1'b1;
         default:                                         return 1'b0;
      endcase
   endfunction

   task automatic check_value(input string name, input logic [XLEN-1:0] exp,
                              input logic [XLEN-1:0] act);
      if (act !== exp) begin
         $display("** Error: %s expected %h actual %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic finish_test(input string name, input int err_before);
      tests_run++;
      if (errors != err_before) begin
         tests_failed++;
         $display("test %-24s mismatch", name);
      end else begin
         $display("test %-24s ok", name);
      end
   endtask

   task automatic start_op(input string name, input alu_op_t op, input logic [XLEN-1:0] a,
                           input logic [XLEN-1:0] b);
      @(posedge clk);
      #2;
      i_op    = op;
      i_rs1   = a;
      i_op_b  = b;
      i_start = 1'b1;
      @(posedge clk);  // accepted here, busy is low.
      #2;
      i_start = 1'b0;
      name_q.push_back(name);
      exp_q.push_back(ref_alu(op, a, b));
      cmp_q.push_back(cmp_defined(op));
      edge_q.push_back(edge_cnt);
   endtask

   task automatic run_op(input string name, input alu_op_t op, input logic [XLEN-1:0] a,
                         input logic [XLEN-1:0] b);
      int done_before;
      done_before = tests_run;
      start_op(name, op, a, b);
      wait (tests_run != done_before);
   endtask

   // ################################################
   // compare on each done pulse
   initial begin : compare
      string         name;
      logic [XLEN:0] exp;
      bit            chk_cmp;
      int            start_edge;
      int            err_before;
      forever begin
         @(negedge clk);
         if (o_done) begin
            if (name_q.size() == 0) begin
               $display("o_done pulsed while no operation was pending");
               errors++;
            end else begin
               name       = name_q.pop_front();
               exp        = exp_q.pop_front();
               chk_cmp    = cmp_q.pop_front();
               start_edge = edge_q.pop_front();
               err_before = errors;
               check_value(name, exp[XLEN-1:0], o_result);
               if (chk_cmp) begin
                  check_value({name, " cmp"}, XLEN'(exp[XLEN]), XLEN'(o_cmp));
               end
               check_value({name, " latency"}, DONE_EDGES, edge_cnt - start_edge);
               finish_test(name, err_before);
            end
         end
      end
   end

   // ################################################
   // stimulus
   initial begin : stimulus
      logic [XLEN-1:0] a;
      logic [XLEN-1:0] b;
      logic [XLEN:0]   exp;
      alu_op_t         op;
      int              err_before;
      int              done_before;
      i_reset   = 1'b1;
      i_start   = 1'b0;
      i_op      = OP_ADD;
      i_rs1     = '0;
      i_op_b    = '0;
      rng_state = 32'd40;
      repeat (4) @(posedge clk);
      #2;
      i_reset = 1'b0;

      @(negedge clk);
      err_before = errors;
      check_value("reset o_busy", '0, XLEN'(o_busy));
      check_value("reset o_done", '0, XLEN'(o_done));
      check_value("reset o_cmp", '0, XLEN'(o_cmp));
      check_value("reset o_result", '0, o_result);
      finish_test("reset_state", err_before);

      // add, sub, slt and sltu over all corner pairs.
      for (int k = 0; k < 4; k++) begin
         op = (k == 0) ? OP_ADD : (k == 1) ? OP_SUB : (k == 2) ? OP_SLT : OP_SLTU;
         for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
               run_op($sformatf("%s_corner_%0d%0d", op.name(), i, j), op, corner(i), corner(j));
            end
         end
      end

      for (int k = 0; k < 4; k++) begin
         op = (k == 0) ? OP_AND : (k == 1) ? OP_OR : (k == 2) ? OP_XOR : OP_XNOR;
         a  = xorshift32();
         run_op($sformatf("%s_equal", op.name()), op, a, a);
         b  = a ^ (xorshift32() | 32'h1);  // always differs.
         run_op($sformatf("%s_unequal", op.name()), op, a, b);
      end

      for (int k = 0; k < 3; k++) begin
         op = (k == 0) ? OP_SLL : (k == 1) ? OP_SRL : OP_SRA;
         for (int s = 0; s < 3; s++) begin
            a = xorshift32() | 32'h8000_0000;
            b = (xorshift32() & ~32'h1f) | ((s == 0) ? 0 : (s == 1) ? 1 : 31);
            run_op($sformatf("%s_shamt_%0d", op.name(), b[SHAMT_W-1:0]), op, a, b);
         end
      end

      for (int n = 0; n < N_RAND; n++) begin
         for (int k = 0; k < 11; k++) begin
            op = alu_op_t'(k);
            a  = xorshift32();
            b  = xorshift32();
            run_op($sformatf("%s_rand_%0d", op.name(), n), op, a, b);
         end
      end

      // ################################################
      // start while busy, then result hold
      done_before = tests_run;
      a = 32'h1234_5678;
      b = 32'h1111_1111;
      start_op("ignored_start", OP_ADD, a, b);
      repeat (10) @(posedge clk);
      #2;
      i_op    = OP_SUB;
      i_rs1   = 32'hdead_beef;
      i_op_b  = 32'h0bad_f00d;
      i_start = 1'b1;
      @(posedge clk);
      #2;
      i_start = 1'b0;
      wait (tests_run != done_before);
      repeat (5) @(negedge clk);
      err_before = errors;
      exp = ref_alu(OP_ADD, a, b);
      check_value("hold o_result", exp[XLEN-1:0], o_result);
      check_value("hold o_busy", '0, XLEN'(o_busy));
      finish_test("result_hold", err_before);

      $display("tests %0d, failed %0d, errors %0d, assertion failures %0d", tests_run,
               tests_failed, errors, dut.u_props.fail_cnt);
      if (errors == 0 && dut.u_props.fail_cnt == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

/* verification/serial_alu_props.sv */
`timescale 1ns/100ps

module serial_alu_props (
   input logic clk,
   input logic i_reset,
   input logic i_start,
   input logic o_busy,
   input logic o_done
);

   logic accept;
   int   fail_cnt = 0;  // failed assertions.

   assign accept = i_start & ~o_busy;

   // ################################################
   // done pulse and latency
   done_one_cycle: assert property (
      @(posedge clk) disable iff (i_reset) o_done |=> !o_done
   ) else begin
      $error("o_done stayed high for more than one cycle");
      fail_cnt++;
   end

   // done is visible after edge 65, so the first sample that sees it is edge 66.
   done_latency: assert property (
      @(posedge clk) disable iff (i_reset) accept |-> ##1 (!o_done [*65]) ##1 o_done
   ) else begin
      $error("o_done did not follow the accepted start after 65 edges");
      fail_cnt++;
   end

   // busy from the accepting edge up to edge 65.
   busy_window: assert property (
      @(posedge clk) disable iff (i_reset) accept |=> (o_busy [*65]) ##1 !o_busy
   ) else begin
      $error("o_busy was not high from the accepted start until edge 65");
      fail_cnt++;
   end

   // ################################################
   // reset state
   reset_idle: assert property (
      @(posedge clk) i_reset |=> (!o_busy && !o_done)
   ) else begin
      $error("o_busy or o_done high after reset");
      fail_cnt++;
   end

endmodule

bind serial_alu_top serial_alu_props u_props (.*);

/* source/serial_alu_top.sv */
`timescale 1ns/100ps

module serial_alu_top
   import serial_alu_pkg::*;
(
   input  logic            clk,
   input  logic            i_reset,
   input  logic            i_start,
   input  alu_op_t         i_op,
   input  logic [XLEN-1:0] i_rs1,
   input  logic [XLEN-1:0] i_op_b,
   output logic            o_busy,
   output logic            o_done,
   output logic            o_cmp,
   output logic [XLEN-1:0] o_result
);

   logic rs1_bit;
   logic op_b_bit;
   logic buf_bit;
   logic rd_bit;
   logic cmp_bit;

   alu_ctrl_if ctrl ();

   alu_sequencer u_seq (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_start    (i_start),
      .i_op       (i_op),
      .i_rs1      (i_rs1),
      .i_op_b     (i_op_b),
      .i_rd_bit   (rd_bit),
      .i_cmp_bit  (cmp_bit),
      .ctrl       (ctrl.seq),
      .o_rs1_bit  (rs1_bit),
      .o_op_b_bit (op_b_bit),
      .o_buf_bit  (buf_bit),
      .o_busy     (o_busy),
      .o_done     (o_done),
      .o_cmp      (o_cmp),
      .o_result   (o_result)
   );

   serial_alu u_alu (
      .clk     (clk),
      .i_reset (i_reset),
      .ctrl    (ctrl.alu),
      .i_rs1   (rs1_bit),
      .i_op_b  (op_b_bit),
      .i_buf   (buf_bit),
      .o_cmp   (cmp_bit),
      .o_rd    (rd_bit)
   );

endmodule

/* source/alu_sequencer.sv */
`timescale 1ns/100ps

module alu_sequencer
   import serial_alu_pkg::*;
(
   input  logic            clk,
   input  logic            i_reset,
   input  logic            i_start,
   input  alu_op_t         i_op,
   input  logic [XLEN-1:0] i_rs1,
   input  logic [XLEN-1:0] i_op_b,
   input  logic            i_rd_bit,
   input  logic            i_cmp_bit,
   alu_ctrl_if.seq         ctrl,
   output logic            o_rs1_bit,
   output logic            o_op_b_bit,
   output logic            o_buf_bit,
   output logic            o_busy,
   output logic            o_done,
   output logic            o_cmp,
   output logic [XLEN-1:0] o_result
);

   logic [CNT_W-1:0] cnt;
   logic             init_r;
   logic             en_r;
   logic             accept;
   logic             last_bit;
   logic [XLEN-1:0]  rs1_r;
   logic [XLEN-1:0]  op_b_r;
   logic [1:0]       rd_sel_d;
   logic [1:0]       bool_op_d;
   logic [1:0]       rd_sel_r;
   logic [1:0]       bool_op_r;
   logic             sub_r;
   logic             cmp_sel_r;
   logic             cmp_uns_r;
   logic             sh_right_r;
   logic             sh_signed_r;

   assign accept   = i_start & ~o_busy;
   assign last_bit = (init_r | en_r) & (&cnt[CNT_W-2:0]);

   // ################################################
   // pass control
   always_ff @(posedge clk) begin
      if (i_reset) begin
         o_busy <= 1'b0;
         o_done <= 1'b0;
         init_r <= 1'b0;
         en_r   <= 1'b0;
         cnt    <= '0;
      end else begin
         o_done <= 1'b0;
         if (accept) begin
            o_busy <= 1'b1;
            cnt    <= '0;
         end else if (last_bit) begin
            init_r <= 1'b0;
            en_r   <= init_r;  // init hands over to run.
            o_busy <= init_r;
            o_done <= en_r;
            cnt    <= cnt + 1'b1;
         end else if (init_r | en_r) begin
            cnt <= cnt + 1'b1;
         end else if (o_busy) begin
            init_r <= 1'b1;  // one gap cycle after start.
         end
      end
   end

   // operands rotate back to where they started.
   always_ff @(posedge clk) begin
      if (accept) begin
         rs1_r  <= i_rs1;
         op_b_r <= i_op_b;
      end else if (init_r | en_r) begin
         rs1_r  <= {rs1_r[0], rs1_r[XLEN-1:1]};
         op_b_r <= {op_b_r[0], op_b_r[XLEN-1:1]};
      end
   end

   // ################################################
   // operation decode
   always_comb begin
      case (i_op)
         OP_AND, OP_OR, OP_XOR, OP_XNOR: rd_sel_d = ALU_RESULT_BOOL;
         OP_SLT, OP_SLTU:                rd_sel_d = ALU_RESULT_LT;
         OP_SLL, OP_SRL, OP_SRA:         rd_sel_d = ALU_RESULT_SR;
         default:                        rd_sel_d = ALU_RESULT_ADD;
      endcase
      case (i_op)
         OP_AND:  bool_op_d = BOOL_AND;
         OP_OR:   bool_op_d = BOOL_OR;
         OP_XNOR: bool_op_d = BOOL_XNOR;
         default: bool_op_d = BOOL_XOR;
      endcase
   end

   always_ff @(posedge clk) begin
      if (i_reset) begin
         rd_sel_r    <= ALU_RESULT_ADD;
         bool_op_r   <= BOOL_XOR;
         sub_r       <= 1'b0;
         cmp_sel_r   <= ALU_CMP_EQ;
         cmp_uns_r   <= 1'b0;
         sh_right_r  <= 1'b0;
         sh_signed_r <= 1'b0;
      end else if (accept) begin
         rd_sel_r    <= rd_sel_d;
         bool_op_r   <= bool_op_d;
         sub_r       <= (i_op == OP_SUB);
         cmp_sel_r   <= (rd_sel_d == ALU_RESULT_LT) ? ALU_CMP_LT : ALU_CMP_EQ;
         cmp_uns_r   <= (i_op == OP_SLTU);
         sh_right_r  <= (i_op == OP_SRL) | (i_op == OP_SRA);
         sh_signed_r <= (i_op == OP_SRA);
      end
   end

   // ################################################
   // result collection
   always_ff @(posedge clk) begin
      if (i_reset) begin
         o_cmp    <= 1'b0;
         o_result <= '0;
      end else begin
         if (init_r & last_bit) begin
            o_cmp <= i_cmp_bit;
         end
         if (en_r) begin
            o_result <= {i_rd_bit, o_result[XLEN-1:1]};  // lsb arrives first.
         end
      end
   end

   assign o_rs1_bit  = rs1_r[0];
   assign o_op_b_bit = op_b_r[0];
   assign o_buf_bit  = rs1_r[0];

   assign ctrl.en        = en_r;
   assign ctrl.init      = init_r;
   assign ctrl.cnt_done  = last_bit;
   assign ctrl.sub       = sub_r;
   assign ctrl.bool_op   = bool_op_r;
   assign ctrl.cmp_sel   = cmp_sel_r;
   assign ctrl.cmp_uns   = cmp_uns_r;
   assign ctrl.shamt_en  = init_r & (cnt < CNT_W'(SHAMT_W));
   assign ctrl.sh_right  = sh_right_r;
   assign ctrl.sh_signed = sh_signed_r;
   assign ctrl.rd_sel    = rd_sel_r;

endmodule

/* source/serial_alu.sv */
`timescale 1ns/100ps

module serial_alu
   import serial_alu_pkg::*;
(
   input  logic    clk,
   input  logic    i_reset,
   alu_ctrl_if.alu ctrl,
   input  logic    i_rs1,
   input  logic    i_op_b,
   input  logic    i_buf,
   output logic    o_cmp,
   output logic    o_rd
);

   logic en_r;
   logic plus_1;
   logic b_inv_plus_1;
   logic add_b;
   logic result_add;
   logic result_sh;
   logic result_lt;
   logic result_lt_r;
   logic result_eq;
   logic eq_r;
   logic result_bool;

   // ################################################
   // add and subtract
   assign plus_1 = ctrl.en & ~en_r;  // first run bit only.

   ser_add u_neg (
      .clk     (clk),
      .i_reset (i_reset),
      .i_a     (~i_op_b),
      .i_b     (plus_1),
      .i_clr   (~ctrl.en),
      .o_q     (b_inv_plus_1),
      .o_carry ()
   );

   assign add_b = ctrl.sub ? b_inv_plus_1 : i_op_b;

   ser_add u_add (
      .clk     (clk),
      .i_reset (i_reset),
      .i_a     (i_rs1),
      .i_b     (add_b),
      .i_clr   (~ctrl.en),
      .o_q     (result_add),
      .o_carry ()
   );

   ser_shift u_shift (
      .clk         (clk),
      .i_reset     (i_reset),
      .i_load      (ctrl.init),
      .i_shamt_en  (ctrl.shamt_en),
      .i_shamt_bit (i_op_b),
      .i_d         (i_buf),
      .i_right     (ctrl.sh_right),
      .i_signed    (ctrl.sh_signed),
      .o_q         (result_sh)
   );

   // ################################################
   // compare
   ser_lt u_lt (
      .clk    (clk),
      .i_a    (i_rs1),
      .i_b    (i_op_b),
      .i_clr  (~ctrl.init),
      .i_sign (ctrl.cnt_done & ~ctrl.cmp_uns),
      .o_q    (result_lt)
   );

   assign result_eq   = eq_r & (i_rs1 == i_op_b);
   assign result_bool = BOOL_LUT[{ctrl.bool_op, i_rs1, i_op_b}];
   assign o_cmp       = (ctrl.cmp_sel == ALU_CMP_EQ) ? result_eq : result_lt;

   always_ff @(posedge clk) begin
      if (i_reset) begin
         en_r        <= 1'b0;
         eq_r        <= 1'b1;
         result_lt_r <= 1'b0;
      end else begin
         en_r <= ctrl.en;
         eq_r <= ctrl.init ? result_eq : 1'b1;
         if (ctrl.init & ctrl.cnt_done) begin
            result_lt_r <= result_lt;  // held for run bit 0.
         end else if (!ctrl.init) begin
            result_lt_r <= 1'b0;
         end
      end
   end

   always_comb begin
      case (ctrl.rd_sel)
         ALU_RESULT_ADD: o_rd = result_add;
         ALU_RESULT_SR:  o_rd = result_sh;
         ALU_RESULT_LT:  o_rd = result_lt_r;
         default:        o_rd = result_bool;
      endcase
   end

endmodule

/* source/ser_shift.sv */
`timescale 1ns/100ps

module ser_shift
   import serial_alu_pkg::*;
(
   input  logic clk,
   input  logic i_reset,
   input  logic i_load,
   input  logic i_shamt_en,
   input  logic i_shamt_bit,
   input  logic i_d,
   input  logic i_right,
   input  logic i_signed,
   output logic o_q
);

   logic [XLEN-1:0]    buffer;
   logic [SHAMT_W-1:0] shamt;
   logic [SHAMT_W-1:0] zero_cnt;
   logic               fill;
   logic               left_go;

   assign fill    = i_signed & buffer[XLEN-1];  // sign for sra, else zero.
   assign left_go = (zero_cnt == '0);

   // ################################################
   // operand buffer
   always_ff @(posedge clk) begin
      if (i_load) begin
         buffer <= {i_d, buffer[XLEN-1:1]};  // fill from the top.
      end else if (i_right | left_go) begin
         buffer <= {fill, buffer[XLEN-1:1]};
      end
   end

   // ################################################
   // shift amount and left zero counter
   always_ff @(posedge clk) begin
      if (i_reset) begin
         shamt    <= '0;
         zero_cnt <= '0;
      end else begin
         if (i_shamt_en) begin
            shamt <= {i_shamt_bit, shamt[SHAMT_W-1:1]};
         end
         if (i_load) begin
            zero_cnt <= shamt;  // final value on last init bit.
         end else if (!left_go) begin
            zero_cnt <= zero_cnt - 1'b1;
         end
      end
   end

   // right reads ahead, left waits out the zeros.
   assign o_q = i_right ? buffer[shamt] : (left_go & buffer[0]);

endmodule

/* source/ser_lt.sv */
`timescale 1ns/100ps

module ser_lt (
   input  logic clk,
   input  logic i_a,
   input  logic i_b,
   input  logic i_clr,
   input  logic i_sign,
   output logic o_q
);

   logic lt_r;
   logic bit_lt;
   logic bit_eq;

   // on the sign bit a set a means a negative.
   assign bit_lt = i_sign ? (i_a & ~i_b) : (~i_a & i_b);
   assign bit_eq = ~(i_a ^ i_b);
   assign o_q    = bit_lt | (bit_eq & lt_r);  // upper bits win.

   always_ff @(posedge clk) begin
      lt_r <= i_clr ? 1'b0 : o_q;
   end

endmodule

/* source/ser_add.sv */
`timescale 1ns/100ps

module ser_add (
   input  logic clk,
   input  logic i_reset,
   input  logic i_a,
   input  logic i_b,
   input  logic i_clr,
   output logic o_q,
   output logic o_carry
);

   logic carry_r;

   assign o_q     = i_a ^ i_b ^ carry_r;
   assign o_carry = (i_a & i_b) | (carry_r & (i_a ^ i_b));  // carry out of this bit.

   always_ff @(posedge clk) begin
      if (i_reset | i_clr) begin
         carry_r <= 1'b0;
      end else begin
         carry_r <= o_carry;
      end
   end

endmodule

/* source/alu_ctrl_if.sv */
`timescale 1ns/100ps

interface alu_ctrl_if;

   logic       en;         // run pass.
   logic       init;       // init pass.
   logic       cnt_done;   // bit 31 of a pass.
   logic       sub;
   logic [1:0] bool_op;
   logic       cmp_sel;
   logic       cmp_uns;
   logic       shamt_en;   // init bits 0 to 4.
   logic       sh_right;
   logic       sh_signed;
   logic [1:0] rd_sel;

   modport seq (
      output en, init, cnt_done, sub, bool_op, cmp_sel, cmp_uns,
      output shamt_en, sh_right, sh_signed, rd_sel
   );

   modport alu (
      input en, init, cnt_done, sub, bool_op, cmp_sel, cmp_uns,
      input shamt_en, sh_right, sh_signed, rd_sel
   );

endinterface

/* source/serial_alu_pkg.sv */
package serial_alu_pkg;

   localparam int XLEN    = 32;
   localparam int CNT_W   = 6;
   localparam int SHAMT_W = 5;

   typedef enum logic [3:0] {
      OP_ADD  = 4'd0,
      OP_SUB  = 4'd1,
      OP_AND  = 4'd2,
      OP_OR   = 4'd3,
      OP_XOR  = 4'd4,
      OP_XNOR = 4'd5,
      OP_SLT  = 4'd6,
      OP_SLTU = 4'd7,
      OP_SLL  = 4'd8,
      OP_SRL  = 4'd9,
      OP_SRA  = 4'd10
   } alu_op_t;

   // ################################################
   // result select, compare select, boolean codes
   localparam logic [1:0] ALU_RESULT_ADD  = 2'd0;
   localparam logic [1:0] ALU_RESULT_SR   = 2'd1;
   localparam logic [1:0] ALU_RESULT_LT   = 2'd2;
   localparam logic [1:0] ALU_RESULT_BOOL = 2'd3;

   localparam logic ALU_CMP_EQ = 1'b0;
   localparam logic ALU_CMP_LT = 1'b1;

   localparam logic [1:0] BOOL_XOR  = 2'd0;
   localparam logic [1:0] BOOL_XNOR = 2'd1;
   localparam logic [1:0] BOOL_OR   = 2'd2;
   localparam logic [1:0] BOOL_AND  = 2'd3;

   localparam logic [15:0] BOOL_LUT = 16'h8E96;  // and, or, xnor, xor nibbles.

endpackage
